// File: Bender.yml
package:
  name: soc_mem

sources:
  - files:
      - rtl/soc_mem_pkg.sv
      - rtl/mem_req_stage.sv
      - rtl/addr_decode_stage.sv
      - rtl/boot_ctrl_regs.sv
      - rtl/uart_tx.sv
      - rtl/slave_access_stage.sv
      - rtl/soc_mem_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_soc_mem.sv

// File: rtl/addr_decode_stage.sv
`timescale 1ns/1ps

module addr_decode_stage (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  stall_i,
	input  soc_mem_pkg::mem_req_t req_i,
	output soc_mem_pkg::dec_req_t dec_o
);
	import soc_mem_pkg::*;

	target_t     tgt_d;
	logic [15:0] offset_d;
	// Registered decode result
	logic        rd_q;
	logic        wr_q;
	addr_t       addr_q;
	data_t       wdata_q;
	strb_t       strb_q;
	target_t     tgt_q;
	logic [15:0] offset_q;

	// Inclusive range check against one map entry
	function automatic logic in_region(addr_t addr, addr_t base, addr_t space);
		return (addr >= base) && (addr <= base + space);
	endfunction

	// Map lookup
	always_comb begin
		tgt_d    = TGT_NONE;
		offset_d = '0;
		if (in_region(req_i.addr, RAM_BASE, RAM_SPACE)) begin
			tgt_d    = TGT_RAM;
			offset_d = 16'(req_i.addr - RAM_BASE);
		end else if (in_region(req_i.addr, BOOT_BASE, BOOT_SPACE)) begin
			tgt_d    = TGT_BOOT;
			offset_d = 16'(req_i.addr - BOOT_BASE);
		end else if (in_region(req_i.addr, UART_BASE, UART_SPACE)) begin
			tgt_d    = TGT_UART;
			offset_d = 16'(req_i.addr - UART_BASE);
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
		end else if (!stall_i) begin
			rd_q <= req_i.rd;
			wr_q <= req_i.wr;
		end
	end

	// Payload follows the live bits, held under stall
	always_ff @(posedge clk_i) begin
		if (!stall_i) begin
			addr_q   <= req_i.addr;
			wdata_q  <= req_i.wdata;
			strb_q   <= req_i.strb;
			tgt_q    <= tgt_d;
			offset_q <= offset_d;
		end
	end

	assign dec_o = '{
		req:    '{rd: rd_q, wr: wr_q, addr: addr_q, wdata: wdata_q, strb: strb_q},
		tgt:    tgt_q,
		offset: offset_q
	};

endmodule

// File: rtl/boot_ctrl_regs.sv
`timescale 1ns/1ps

module boot_ctrl_regs (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic [1:0]          boot_source_i,
	input  logic                rd_i,
	input  logic [7:0]          offset_i,
	output soc_mem_pkg::data_t  rdata_o
);
	import soc_mem_pkg::*;

	// Strap value sampled while reset is held
	logic [1:0] source_q;
	addr_t      vector;

	// Pins are only meaningful during reset
	// Value stays frozen once reset drops
	always_ff @(posedge clk_i) begin
		if (reset_i)
			source_q <= boot_source_i;
	end

	// Boot vector from the strap code
	always_comb begin
		case (source_q)
			BOOT_SPI:  vector = SPI_BASE;
			BOOT_SRAM: vector = RAM_BASE;
			BOOT_DDR:  vector = DDR_BASE;
			// Reserved code falls back to on-chip RAM
			default:   vector = RAM_BASE;
		endcase
	end

	// Read-only block
	always_comb begin
		rdata_o = '0;
		if (rd_i) begin
			case (offset_i)
				BOOT_REG_SOURCE: rdata_o = {30'd0, source_q};
				BOOT_REG_VECTOR: rdata_o = vector;
				default:         rdata_o = '0;
			endcase
		end
	end

endmodule

// File: rtl/mem_req_stage.sv
`timescale 1ns/1ps

module mem_req_stage (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 stall_i,
	input  soc_mem_pkg::mem_req_t req_i,
	output soc_mem_pkg::mem_req_t req_o
);
	import soc_mem_pkg::*;

	// Live bits, a bubble has both low
	logic  rd_q;
	logic  wr_q;
	// Request payload
	addr_t addr_q;
	data_t wdata_q;
	strb_t strb_q;

	// Capture a new request or a bubble unless frozen
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
		end else if (!stall_i) begin
			rd_q <= req_i.rd;
			wr_q <= req_i.wr;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!stall_i) begin
			addr_q  <= req_i.addr;
			wdata_q <= req_i.wdata;
			// Reads never carry byte lanes downstream
			strb_q  <= req_i.rd ? '0 : req_i.strb;
		end
	end

	assign req_o = '{rd: rd_q, wr: wr_q, addr: addr_q, wdata: wdata_q, strb: strb_q};

endmodule

// File: rtl/slave_access_stage.sv
`timescale 1ns/1ps

module slave_access_stage (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic [1:0]            boot_source_i,
	input  soc_mem_pkg::dec_req_t dec_i,
	output logic                  stall_o,
	output soc_mem_pkg::mem_rsp_t rsp_o,
	output logic                  tx_o
);
	import soc_mem_pkg::*;

	// On-chip RAM, no reset on the array
	data_t                 ram [RAM_WORDS];
	logic [RAM_ADDR_W-1:0] ram_idx;

	logic  live;
	logic  ram_rd;
	logic  ram_wr;
	logic  boot_rd;
	logic  uart_data_wr;
	logic  uart_load;
	logic  uart_busy;
	data_t boot_rdata;
	data_t rdata_d;
	// Response registers
	logic  rsp_valid_q;
	logic  rsp_err_q;
	data_t rdata_q;

	assign live    = dec_i.req.rd | dec_i.req.wr;
	// Word index, upper RAM offsets wrap onto the stored words
	assign ram_idx = dec_i.offset[RAM_ADDR_W+1:2];
	assign ram_rd  = dec_i.req.rd && (dec_i.tgt == TGT_RAM);
	assign ram_wr  = dec_i.req.wr && (dec_i.tgt == TGT_RAM);
	assign boot_rd = dec_i.req.rd && (dec_i.tgt == TGT_BOOT);

	// UART data write
	assign uart_data_wr = dec_i.req.wr && (dec_i.tgt == TGT_UART) &&
		(dec_i.offset[7:0] == UART_REG_DATA);

	// Hold the whole pipe while the transmitter still owns the last byte
	assign stall_o   = uart_data_wr && uart_busy;
	assign uart_load = uart_data_wr && !uart_busy;

	boot_ctrl_regs i_boot_ctrl_regs (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.boot_source_i (boot_source_i),
		.rd_i          (boot_rd),
		.offset_i      (dec_i.offset[7:0]),
		.rdata_o       (boot_rdata)
	);

	uart_tx i_uart_tx (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.load_i  (uart_load),
		.byte_i  (dec_i.req.wdata[7:0]),
		.busy_o  (uart_busy),
		.tx_o    (tx_o)
	);

	// Byte-lane writes
	always_ff @(posedge clk_i) begin
		if (ram_wr && !stall_o) begin
			for (int b = 0; b < 4; b++) begin
				if (dec_i.req.strb[b])
					ram[ram_idx][8*b +: 8] <= dec_i.req.wdata[8*b +: 8];
			end
		end
	end

	// Peripheral read data
	// Writes and unmapped holes return zero
	always_comb begin
		rdata_d = '0;
		if (dec_i.req.rd) begin
			case (dec_i.tgt)
				TGT_BOOT: rdata_d = boot_rdata;
				TGT_UART: begin
					if (dec_i.offset[7:0] == UART_REG_STATUS)
						rdata_d = {31'd0, uart_busy};
				end
				default: rdata_d = '0;
			endcase
		end
	end

	// Synchronous RAM read shares the response register
	always_ff @(posedge clk_i) begin
		if (!stall_o)
			rdata_q <= ram_rd ? ram[ram_idx] : rdata_d;
	end

	// One response pulse per live item, none while frozen
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			rsp_valid_q <= 1'b0;
			rsp_err_q   <= 1'b0;
		end else begin
			rsp_valid_q <= live && !stall_o;
			rsp_err_q   <= live && (dec_i.tgt == TGT_NONE);
		end
	end

	assign rsp_o = '{valid: rsp_valid_q, err: rsp_err_q, rdata: rdata_q};

endmodule

// File: rtl/soc_mem_pkg.sv
package soc_mem_pkg;

	// Basic bus word types
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;

	// CPU data request as it moves down the pipeline
	typedef struct packed {
		logic  rd;
		logic  wr;
		addr_t addr;
		data_t wdata;
		strb_t strb;
	} mem_req_t;

	// Decoded slave select
	typedef enum logic [1:0] {
		TGT_RAM,
		TGT_BOOT,
		TGT_UART,
		TGT_NONE
	} target_t;

	// Request plus its decode result from stage 2
	typedef struct packed {
		mem_req_t    req;
		target_t     tgt;
		logic [15:0] offset;
	} dec_req_t;

	// Response back to the CPU
	typedef struct packed {
		logic  valid;
		logic  err;
		data_t rdata;
	} mem_rsp_t;

	// Address map
	localparam addr_t RAM_BASE   = 32'h00000;
	localparam addr_t RAM_SPACE  = 32'h2ffff;
	localparam addr_t BOOT_BASE  = 32'h30000;
	localparam addr_t BOOT_SPACE = 32'hff;
	localparam addr_t UART_BASE  = 32'h40000;
	localparam addr_t UART_SPACE = 32'hff;
	// Boot vectors only, no slave behind these
	localparam addr_t SPI_BASE   = 32'h60000;
	localparam addr_t DDR_BASE   = 32'h10000000;

	// Physical RAM depth, higher word addresses alias
	localparam int RAM_WORDS  = 1024;
	localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

	// Strap codes for the boot source
	localparam logic [1:0] BOOT_SPI  = 2'd0;
	localparam logic [1:0] BOOT_SRAM = 2'd1;
	localparam logic [1:0] BOOT_DDR  = 2'd2;

	// Register offsets
	localparam logic [7:0] BOOT_REG_SOURCE = 8'h00;
	localparam logic [7:0] BOOT_REG_VECTOR = 8'h04;
	localparam logic [7:0] UART_REG_DATA   = 8'h00;
	localparam logic [7:0] UART_REG_STATUS = 8'h04;

	// UART bit timing
	localparam int UART_CLKS_PER_BIT = 4;
	localparam int UART_TIMER_W      = $clog2(UART_CLKS_PER_BIT + 1);
	localparam int UART_FRAME_BITS   = 10;

endpackage

// File: rtl/soc_mem_top.sv
`timescale 1ns/1ps

module soc_mem_top (
	input  logic                  clk_i,
	input  logic                  reset_i,
	// Boot source straps
	// 0 SPI, 1 SRAM, 2 DDR
	input  logic [1:0]            boot_source_i,
	// CPU data port
	input  soc_mem_pkg::mem_req_t req_i,
	output logic                  mem_ready_o,
	output soc_mem_pkg::mem_rsp_t rsp_o,
	// Serial out
	output logic                  tx_o
);
	import soc_mem_pkg::*;

	// Stage 1 to stage 2
	mem_req_t s1_req;
	// Stage 2 to stage 3
	dec_req_t s2_dec;
	// Freezes every stage
	logic     stall;

	mem_req_stage i_mem_req_stage (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.stall_i (stall),
		.req_i   (req_i),
		.req_o   (s1_req)
	);

	addr_decode_stage i_addr_decode_stage (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.stall_i (stall),
		.req_i   (s1_req),
		.dec_o   (s2_dec)
	);

	slave_access_stage i_slave_access_stage (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.boot_source_i (boot_source_i),
		.dec_i         (s2_dec),
		.stall_o       (stall),
		.rsp_o         (rsp_o),
		.tx_o          (tx_o)
	);

	// CPU waits while the pipe is frozen
	assign mem_ready_o = ~stall;

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
	input  logic       clk_i,
	input  logic       reset_i,
	input  logic       load_i,
	input  logic [7:0] byte_i,
	output logic       busy_o,
	output logic       tx_o
);
	import soc_mem_pkg::*;

	logic                    busy_q;
	logic                    tx_q;
	// Clocks within the current bit
	logic [UART_TIMER_W-1:0] timer_q;
	// Bit position in the frame, 0 is the start bit
	logic [3:0]              bit_cnt_q;
	// Data bits still to go, LSB first
	logic [7:0]              shift_q;
	logic                    start;
	logic                    bit_end;

	assign start   = load_i && !busy_q;
	assign bit_end = busy_q && (timer_q == UART_TIMER_W'(UART_CLKS_PER_BIT - 1));

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q    <= 1'b0;
			tx_q      <= 1'b1;
			timer_q   <= '0;
			bit_cnt_q <= '0;
		end else if (start) begin
			// Start bit goes out right away
			busy_q    <= 1'b1;
			tx_q      <= 1'b0;
			timer_q   <= '0;
			bit_cnt_q <= '0;
		end else if (bit_end) begin
			timer_q <= '0;
			if (bit_cnt_q == 4'(UART_FRAME_BITS - 1)) begin
				// Stop bit done, back to idle
				busy_q <= 1'b0;
				tx_q   <= 1'b1;
			end else begin
				bit_cnt_q <= bit_cnt_q + 4'd1;
				tx_q      <= shift_q[0];
			end
		end else if (busy_q) begin
			timer_q <= timer_q + 1'b1;
		end
	end

	// Ones shift in behind the data
	// Stop bit comes out of the same register
	always_ff @(posedge clk_i) begin
		if (start)
			shift_q <= byte_i;
		else if (bit_end)
			shift_q <= {1'b1, shift_q[7:1]};
	end

	assign busy_o = busy_q;
	assign tx_o   = tx_q;

endmodule

// File: soc_mem.f
+incdir+tb
rtl/soc_mem_pkg.sv
rtl/mem_req_stage.sv
rtl/addr_decode_stage.sv
rtl/boot_ctrl_regs.sv
rtl/uart_tx.sv
rtl/slave_access_stage.sv
rtl/soc_mem_top.sv
tb/tb_soc_mem.sv

// File: tb/soc_mem_tasks.svh
// Bus tasks assume the caller sits 1 ns after a rising edge

// One clock step, lands 1 ns past the edge
task automatic step_clk();
	@(posedge clk_i);
	#1;
endtask

// Drive a request and hold it until the DUT takes it
task automatic issue(input logic rd, input logic wr, input addr_t addr,
		input data_t wdata, input strb_t strb);
	logic taken;
	req_i = '{rd: rd, wr: wr, addr: addr, wdata: wdata, strb: strb};
	do begin
		// Ready only changes on edges, so this is the value the edge sees
		taken = mem_ready_o;
		step_clk();
	end while (!taken);
endtask

// Bubble on the CPU port
task automatic bus_idle();
	req_i = '0;
endtask

// Wait for every outstanding response
task automatic wait_drain();
	while (exp_q.size() != 0)
		step_clk();
	step_clk();
endtask

// Reset run with a given strap code
task automatic apply_reset(input logic [1:0] code);
	boot_source_i = code;
	reset_i       = 1'b1;
	repeat (16) step_clk();
	reset_i       = 1'b0;
	step_clk();
endtask

// Decode one serial frame, sampled mid-bit
task automatic capture_frame(output logic [7:0] data, output logic framing_ok);
	do
		step_clk();
	while (tx_o !== 1'b0);
	// Middle of the start bit
	repeat (UART_CLKS_PER_BIT / 2) step_clk();
	framing_ok = (tx_o === 1'b0);
	for (int i = 0; i < 8; i++) begin
		repeat (UART_CLKS_PER_BIT) step_clk();
		data[i] = tx_o;
	end
	// Stop bit
	repeat (UART_CLKS_PER_BIT) step_clk();
	framing_ok = framing_ok && (tx_o === 1'b1);
endtask

// File: tb/tb_soc_mem.sv
`timescale 1ns/1ps

module tb_soc_mem;
	import soc_mem_pkg::*;

	// Expected response plus bookkeeping for latency
	typedef struct packed {
		logic        err;
		data_t       rdata;
		logic [31:0] cycle;
		logic [31:0] stalls;
	} exp_t;

	localparam int BURST_LEN    = 40;
	localparam int NUM_ACCESSES = 17 + 2 + BURST_LEN + 4 * 6 + 3 + 9;
	localparam int NUM_FRAMES   = 2;
	localparam int NUM_RESETS   = 5;
	// Each access costs at most pipeline depth plus drain
	localparam int CYCLE_LIMIT  = (NUM_ACCESSES * 4 + NUM_RESETS * 18 +
		NUM_FRAMES * UART_FRAME_BITS * UART_CLKS_PER_BIT) * 2;

	logic       clk_i;
	logic       reset_i;
	logic [1:0] boot_source_i;
	mem_req_t   req_i;
	logic       mem_ready_o;
	mem_rsp_t   rsp_o;
	logic       tx_o;

	// Reference model state
	data_t      ram_model [int];
	exp_t       exp_q [$];
	exp_t       head;
	logic       head_valid;
	logic [1:0] boot_code_exp;
	data_t      uart_status_exp;
	int         cyc;
	int         stall_total;
	int         errors;
	int         checked;
	int         seed;

	soc_mem_top uut (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.boot_source_i (boot_source_i),
		.req_i         (req_i),
		.mem_ready_o   (mem_ready_o),
		.rsp_o         (rsp_o),
		.tx_o          (tx_o)
	);

	`include "soc_mem_tasks.svh"

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// Expected response from the address map rules
	task automatic predict(input mem_req_t r, output exp_t e);
		int    idx;
		data_t word;
		e = '0;
		if (r.addr >= RAM_BASE && r.addr <= RAM_BASE + RAM_SPACE) begin
			// Word index aliases on the stored depth
			idx  = ((r.addr - RAM_BASE) >> 2) % RAM_WORDS;
			word = ram_model.exists(idx) ? ram_model[idx] : '0;
			if (r.wr) begin
				for (int b = 0; b < 4; b++)
					if (r.strb[b])
						word[8*b +: 8] = r.wdata[8*b +: 8];
				ram_model[idx] = word;
			end else begin
				e.rdata = word;
			end
		end else if (r.addr >= BOOT_BASE && r.addr <= BOOT_BASE + BOOT_SPACE) begin
			if (r.rd && r.addr[7:0] == BOOT_REG_SOURCE)
				e.rdata = {30'd0, boot_code_exp};
			else if (r.rd && r.addr[7:0] == BOOT_REG_VECTOR)
				e.rdata = (boot_code_exp == 2'd0) ? SPI_BASE :
					(boot_code_exp == 2'd2) ? DDR_BASE : RAM_BASE;
		end else if (r.addr >= UART_BASE && r.addr <= UART_BASE + UART_SPACE) begin
			if (r.rd && r.addr[7:0] == UART_REG_STATUS)
				e.rdata = uart_status_exp;
		end else begin
			// Holes in the map
			e.err = 1'b1;
		end
	endtask

	// Scoreboard and watchdog
	always @(posedge clk_i) begin
		exp_t e;
		if (!reset_i) begin
			if (!mem_ready_o)
				stall_total++;
			if (rsp_o.valid && exp_q.size() > 0) begin
				void'(exp_q.pop_front());
				checked++;
			end
			if ((req_i.rd || req_i.wr) && mem_ready_o) begin
				predict(req_i, e);
				e.cycle  = cyc;
				e.stalls = stall_total;
				exp_q.push_back(e);
			end
		end
		head_valid = (exp_q.size() > 0);
		head       = head_valid ? exp_q[0] : '0;
		cyc++;
		if (cyc > CYCLE_LIMIT) begin
			$display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors: %0d, responses checked: %0d", errors, checked);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// Idle outputs while reset is held and one cycle after
	a_reset_idle: assert property (@(posedge clk_i)
		$past(reset_i) |-> (mem_ready_o && !rsp_o.valid && tx_o))
		else begin
			errors++;
			$display("[ERROR] %0t: outputs not idle around reset", $time);
		end

	a_rsp_expected: assert property (@(posedge clk_i)
		disable iff (reset_i) rsp_o.valid |-> head_valid)
		else begin
			errors++;
			$display("Response pulse arrived with no request outstanding");
		end

	a_rsp_value: assert property (@(posedge clk_i)
		disable iff (reset_i) rsp_o.valid |-> (rsp_o.err == head.err &&
			rsp_o.rdata == head.rdata))
		else begin
			errors++;
			$display("[ERROR] %0t: rsp err %b data %h, expected err %b data %h", $time,
				$sampled(rsp_o.err), $sampled(rsp_o.rdata), $sampled(head.err),
				$sampled(head.rdata));
		end

	// Fixed latency unless a stall hit the request in flight
	a_latency: assert property (@(posedge clk_i)
		disable iff (reset_i) (rsp_o.valid && head_valid && stall_total == head.stalls)
		|-> (cyc == head.cycle + 3))
		else begin
			errors++;
			$display("[ERROR] %0t: response latency %0d cycles, expected 3", $time,
				$sampled(cyc) - $sampled(head.cycle));
		end

	initial begin
		logic [7:0] byte_a;
		logic [7:0] byte_b;
		logic [7:0] got_a;
		logic [7:0] got_b;
		logic       ok_a;
		logic       ok_b;
		int         stall_start;
		seed            = 32'hb86c;
		errors          = 0;
		checked         = 0;
		cyc             = 0;
		stall_total     = 0;
		uart_status_exp = '0;
		boot_code_exp   = BOOT_SRAM;
		req_i           = '0;
		boot_source_i   = BOOT_SRAM;
		reset_i         = 1'b1;
		#1;
		apply_reset(BOOT_SRAM);

		// Known contents for the words the burst touches
		for (int w = 0; w < 16; w++)
			issue(1'b0, 1'b1, RAM_BASE + 4 * w, $random(seed), 4'hf);
		issue(1'b0, 1'b1, RAM_BASE + 32'h100, $random(seed), 4'hf);
		bus_idle();
		wait_drain();

		// Partial write then readback
		issue(1'b0, 1'b1, RAM_BASE + 32'h14, $random(seed), 4'($random(seed)));
		issue(1'b1, 1'b0, RAM_BASE + 32'h14, '0, '0);
		bus_idle();
		wait_drain();

		// Back-to-back mix, one per cycle
		for (int i = 0; i < BURST_LEN; i++) begin
			if ($random(seed) & 1)
				issue(1'b1, 1'b0, RAM_BASE + 4 * ($unsigned($random(seed)) % 16), '0, '0);
			else
				issue(1'b0, 1'b1, RAM_BASE + 4 * ($unsigned($random(seed)) % 16),
					$random(seed), 4'($random(seed)));
		end
		bus_idle();
		wait_drain();

		// Strap capture for every code
		for (int code = 0; code < 4; code++) begin
			apply_reset(2'(code));
			boot_code_exp = 2'(code);
			// Pins move after reset, latched value must not
			boot_source_i = ~2'(code);
			issue(1'b1, 1'b0, BOOT_BASE + BOOT_REG_SOURCE, '0, '0);
			issue(1'b1, 1'b0, BOOT_BASE + BOOT_REG_VECTOR, '0, '0);
			issue(1'b0, 1'b1, BOOT_BASE + BOOT_REG_SOURCE, 32'hffff_ffff, 4'hf);
			issue(1'b0, 1'b1, BOOT_BASE + BOOT_REG_VECTOR, 32'hdead_beef, 4'hf);
			issue(1'b1, 1'b0, BOOT_BASE + BOOT_REG_SOURCE, '0, '0);
			issue(1'b1, 1'b0, BOOT_BASE + BOOT_REG_VECTOR, '0, '0);
			bus_idle();
			wait_drain();
		end

		// Two UART bytes back to back, second one stalls
		byte_a      = 8'($random(seed));
		byte_b      = 8'($random(seed));
		stall_start = stall_total;
		fork
			begin
				capture_frame(got_a, ok_a);
				capture_frame(got_b, ok_b);
			end
			begin
				issue(1'b0, 1'b1, UART_BASE + UART_REG_DATA, {24'd0, byte_a}, 4'h1);
				issue(1'b0, 1'b1, UART_BASE + UART_REG_DATA, {24'd0, byte_b}, 4'h1);
				// Transmitter is busy on the second frame here
				uart_status_exp = 32'd1;
				issue(1'b1, 1'b0, UART_BASE + UART_REG_STATUS, '0, '0);
				bus_idle();
			end
		join
		wait_drain();
		uart_status_exp = '0;
		a_frame_a: assert (ok_a && got_a == byte_a)
			else begin
				errors++;
				$display("[ERROR] %0t: first frame %h, expected %h", $time, got_a, byte_a);
			end
		a_frame_b: assert (ok_b && got_b == byte_b)
			else begin
				errors++;
				$display("[ERROR] %0t: second frame %h, expected %h", $time, got_b, byte_b);
			end
		// Ready stays low for the whole first frame
		a_uart_stall: assert (stall_total - stall_start ==
			UART_FRAME_BITS * UART_CLKS_PER_BIT)
			else begin
				errors++;
				$display("[ERROR] %0t: UART stall lasted %0d cycles, expected %0d", $time,
					stall_total - stall_start, UART_FRAME_BITS * UART_CLKS_PER_BIT);
			end

		// Unmapped holes
		issue(1'b1, 1'b0, SPI_BASE, '0, '0);
		issue(1'b0, 1'b1, SPI_BASE, 32'h1111_1111, 4'hf);
		issue(1'b1, 1'b0, DDR_BASE, '0, '0);
		issue(1'b0, 1'b1, DDR_BASE, 32'h2222_2222, 4'hf);
		issue(1'b0, 1'b1, BOOT_BASE + BOOT_SPACE + 1, 32'h3333_3333, 4'hf);
		issue(1'b1, 1'b0, UART_BASE + UART_SPACE + 1, '0, '0);
		// Words that a misdecoded write would hit
		issue(1'b1, 1'b0, RAM_BASE, '0, '0);
		issue(1'b1, 1'b0, RAM_BASE + 32'h100, '0, '0);
		issue(1'b1, 1'b0, RAM_BASE + 32'h14, '0, '0);
		bus_idle();
		wait_drain();

		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d responses never arrived", exp_q.size());
		end
		$display("Errors: %0d, responses checked: %0d", errors, checked);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
